//--- board_clocks.f
source/clk_cfg_pkg.sv
source/rst_cfg_pkg.sv
source/clk_bus_if.sv
source/clock_gen.sv
source/reset_sync.sv
source/board_clocks.sv
test/tb_board_clocks.sv

//--- run_sim.sh
#!/bin/sh
# build the board_clocks testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f board_clocks.f \
    --top-module tb_board_clocks \
    -o sim_tb_board_clocks

output=$(./obj_dir/sim_tb_board_clocks) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

//--- source/board_clocks.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// arcade-core clock and reset block, generator plus three domain resets
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module board_clocks #(
    parameter int unsigned           LOCK_CYCLES = clk_cfg_pkg::lock_cycles_default,
    parameter clk_cfg_pkg::rom_sel_t ROM_SEL     = clk_cfg_pkg::rom_48,
    parameter clk_cfg_pkg::sys_sel_t SYS_SEL     = clk_cfg_pkg::sys_rom,
    parameter logic [7:0]            RST_STRETCH = rst_cfg_pkg::rst_stretch_default
) (
    input  logic clk_ext,       // board reference, 96 MHz in this model
    input  logic rst_n,         // board reset

    // PLL outputs
    output logic clk96,
    output logic clk48,
    output logic clk24,
    output logic pll_locked,

    // system clocks
    output logic clk_sys,
    output logic clk_rom,
    output logic SDRAM_CLK,     // 180 degrees from clk_rom

    // resets
    input  logic game_rst,      // from the core, domain resets only
    output logic rst96,
    output logic rst48,
    output logic rst24
);

    clk_bus_if clk_bus ();

    clock_gen #(
        .LOCK_CYCLES ( LOCK_CYCLES ),
        .ROM_SEL     ( ROM_SEL     ),
        .SYS_SEL     ( SYS_SEL     )
    ) u_clock_gen (
        .clk_ext     ( clk_ext     ),
        .rst_n       ( rst_n       ),
        .bus         ( clk_bus.gen ),
        .clk_sys     ( clk_sys     ),
        .clk_rom     ( clk_rom     ),
        .sdram_clk   ( SDRAM_CLK   )
    );

    // core clocks out of the bus
    assign clk96      = clk_bus.clk96;
    assign clk48      = clk_bus.clk48;
    assign clk24      = clk_bus.clk24;
    assign pll_locked = clk_bus.locked;

    reset_sync #(.DOMAIN(0), .RST_STRETCH(RST_STRETCH)) u_reset96 (
        .bus      ( clk_bus.sink ),
        .rst_n    ( rst_n        ),
        .game_rst ( game_rst     ),
        .rst      ( rst96        )
    );

    reset_sync #(.DOMAIN(1), .RST_STRETCH(RST_STRETCH)) u_reset48 (
        .bus      ( clk_bus.sink ),
        .rst_n    ( rst_n        ),
        .game_rst ( game_rst     ),
        .rst      ( rst48        )
    );

    // slowest domain, releases last
    reset_sync #(.DOMAIN(2), .RST_STRETCH(RST_STRETCH)) u_reset24 (
        .bus      ( clk_bus.sink ),
        .rst_n    ( rst_n        ),
        .game_rst ( game_rst     ),
        .rst      ( rst24        )
    );

endmodule

//--- source/clk_bus_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// generated core clocks and lock flag, from the generator to the resets
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

interface clk_bus_if;

    logic clk96;    // PLL output, here the board clock itself
    logic clk48;    // clk96 / 2
    logic clk24;    // clk96 / 4
    logic locked;   // level, high once the PLL model has settled

    // clock generator side
    modport gen (
        output clk96,
        output clk48,
        output clk24,
        output locked
    );

    // reset synchronizers only look
    modport sink (
        input clk96,
        input clk48,
        input clk24,
        input locked
    );

endinterface

//--- source/clk_cfg_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clock configuration for the arcade-core clock block
// lock time model and the ROM / system clock source choices
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package clk_cfg_pkg;

    // clk_ext cycles from board reset release until the PLL model locks
    // a real PLL needs far longer, this only keeps simulation short
    localparam int unsigned lock_cycles_default = 32'd64;

    // where clk_rom comes from
    // 48 MHz is the usual SDRAM rate, 96 MHz for cores that need the bandwidth
    typedef enum logic {
        rom_48 = 1'b0,  // clk_rom follows clk48
        rom_96 = 1'b1   // clk_rom follows clk96
    } rom_sel_t;

    // where clk_sys comes from
    typedef enum logic {
        sys_rom = 1'b0, // video shares the ROM clock
        sys_96  = 1'b1  // video runs at 96 MHz, independent of the ROM side
    } sys_sel_t;

    // rough ratio between the core clocks
    // clk96 : clk48 : clk24 = 4 : 2 : 1, all from toggle division
    //
    // SDRAM clock
    // always the ROM clock inverted, a fixed 180 degree shift

endpackage

//--- source/clock_gen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PLL stand-in, toggle dividers for clk48 / clk24, lock timer
// and selection of the system, ROM and SDRAM clocks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module clock_gen #(
    parameter int unsigned           LOCK_CYCLES = clk_cfg_pkg::lock_cycles_default,
    parameter clk_cfg_pkg::rom_sel_t ROM_SEL     = clk_cfg_pkg::rom_48,
    parameter clk_cfg_pkg::sys_sel_t SYS_SEL     = clk_cfg_pkg::sys_rom
) (
    input  logic      clk_ext,      // stands in for the 96 MHz PLL output
    input  logic      rst_n,        // board reset, restarts the lock timer
    clk_bus_if.gen    bus,
    output logic      clk_sys,      // video side clock
    output logic      clk_rom,      // SDRAM controller clock
    output logic      sdram_clk     // clock pin to the SDRAM chip
);

    // counter just wide enough to hold LOCK_CYCLES
    localparam int unsigned CNT_W = $clog2(LOCK_CYCLES + 1);

    logic             div2;         // clk48 flop
    logic             div4;         // clk24 flop
    logic [CNT_W-1:0] lock_cnt;     // saturating lock timer
    logic             lock_done;

    // 96 MHz goes straight through
    assign bus.clk96 = clk_ext;

    // dividers
    // both flops sit on clk_ext so the board reset reaches them
    // even when the divided clocks are parked low
    always_ff @(posedge clk_ext) begin
        if (!rst_n) begin
            div2 <= 1'b0;
            div4 <= 1'b0;
        end else begin
            div2 <= ~div2;          // every clk_ext edge
            if (!div2) begin
                div4 <= ~div4;      // only on the edges where clk48 rises
            end
        end
    end

    assign bus.clk48 = div2;
    assign bus.clk24 = div4;

    // lock timer
    // counts clk_ext edges that see rst_n high, then sticks at the top
    always_ff @(posedge clk_ext) begin
        if (!rst_n) begin
            lock_cnt <= '0;
        end else if (!lock_done) begin
            lock_cnt <= lock_cnt + 1'b1;
        end
    end

    // high right after the LOCK_CYCLES-th edge since release
    assign lock_done  = (lock_cnt == CNT_W'(LOCK_CYCLES));
    assign bus.locked = lock_done;

    // clock selection
    // parameters are fixed, so these collapse to plain wires
    always_comb begin
        if (ROM_SEL == clk_cfg_pkg::rom_96) begin
            clk_rom = clk_ext;
        end else begin
            clk_rom = div2;         // default, 48 MHz SDRAM
        end
    end

    always_comb begin
        if (SYS_SEL == clk_cfg_pkg::sys_96) begin
            clk_sys = clk_ext;      // HQ video mixers may dislike this one
        end else begin
            clk_sys = clk_rom;
        end
    end

    // fixed 180 degree shift of the ROM clock
    // data from the controller is stable at the chip's rising edge
    assign sdram_clk = ~clk_rom;

    // once locked, only a board reset may drop the flag
    a_lock_holds: assert property (
        @(posedge clk_ext) (rst_n && lock_done) |=> lock_done
    ) else begin
        $error("pll_locked fell without a board reset");
    end

endmodule

//--- source/reset_sync.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-domain reset, two-flop synchronizer plus a release stretch
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module reset_sync #(
    parameter int         DOMAIN      = 0,  // 0 = clk96, 1 = clk48, 2 = clk24
    parameter logic [7:0] RST_STRETCH = rst_cfg_pkg::rst_stretch_default
) (
    clk_bus_if.sink bus,
    input  logic    rst_n,          // board reset
    input  logic    game_rst,       // core reset, level
    output logic    rst             // domain reset, active high
);

    localparam int STAGES = rst_cfg_pkg::sync_stages;

    logic              dom_clk;     // the clock of this domain
    logic              cause;       // raw reset cause, not yet in the domain
    logic [STAGES-1:0] sync_q;      // synchronizer chain
    logic              sync_cause;  // cause as seen in the domain
    logic [7:0]        stretch_cnt; // release hold-off

    // pick the domain clock off the bus
    generate
        case (DOMAIN)
            0: begin : g_clk96
                assign dom_clk = bus.clk96;
            end
            1: begin : g_clk48
                assign dom_clk = bus.clk48;
            end
            default: begin : g_clk24
                assign dom_clk = bus.clk24;
            end
        endcase
    endgenerate

    // anything that should hold the core in reset
    assign cause = !rst_n || !bus.locked || game_rst;

    // synchronizer
    // preset on board reset, the cause is active then anyway
    always_ff @(posedge dom_clk) begin
        if (!rst_n) begin
            sync_q <= '1;
        end else begin
            sync_q <= {sync_q[STAGES-2:0], cause};
        end
    end

    assign sync_cause = sync_q[STAGES-1];

    // reload while the cause is there, count down once it is gone
    always_ff @(posedge dom_clk) begin
        if (!rst_n || sync_cause) begin
            stretch_cnt <= RST_STRETCH;
        end else if (stretch_cnt != 8'd0) begin
            stretch_cnt <= stretch_cnt - 8'd1;
        end
    end

    // rises one edge after the chain's first stage sees the cause
    // falls STAGES + RST_STRETCH edges after the cause was last sampled
    assign rst = sync_cause || (stretch_cnt != 8'd0);

    // lock loss from the generator must reach this domain in two cycles
    a_unlocked_rst: assert property (
        @(posedge dom_clk) (!bus.locked ##1 !bus.locked) |=> rst
    ) else begin
        $error("domain %0d out of reset while PLL unlocked", DOMAIN);
    end

    // release only after the whole stretch, counted from the last active
    // synchronized cause
    a_no_early_release: assert property (
        @(posedge dom_clk) $fell(rst) |-> $past(sync_cause, RST_STRETCH + 1)
    ) else begin
        $error("domain %0d reset released off the stretch timing", DOMAIN);
    end

endmodule

//--- source/rst_cfg_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reset configuration, synchronizer depth and release stretch
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rst_cfg_pkg;

    // flops between the raw reset cause and the stretch counter
    // two is enough for the level signals seen here
    localparam int sync_stages = 2;

    // extra domain cycles that a reset stays high after its cause ends
    // gives the core a few clean cycles with the clock already running
    localparam logic [7:0] rst_stretch_default = 8'd4;

    // total release latency in domain cycles is
    //   sync_stages + stretch
    // measured from the last edge that sees the cause active
    //
    // a reset cause is any of
    //   board reset low
    //   PLL not locked
    //   game reset from the core
    //
    // the assert side needs no stretch, the cause shows up on rst
    // as soon as it leaves the synchronizer

endpackage

//--- test/tb_board_clocks.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the arcade-core clock and reset block
// cycle model of dividers, lock timer and domain resets, checked every cycle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module tb_board_clocks;

    localparam int LOCK_CYCLES  = 64;   // even, so lock never moves on a clk48 rise
    localparam int STRETCH      = 4;
    localparam int RESET_CYCLES = 16;
    localparam int PULSES       = 10;
    // 2 x (reset + lock + release) plus 10 x (8 + 100) is about 1300 cycles
    localparam int MAX_CYCLES   = 4000;

    logic clk_ext;
    logic rst_n;
    logic game_rst;
    logic clk96;
    logic clk48;
    logic clk24;
    logic pll_locked;
    logic clk_sys;
    logic clk_rom;
    logic SDRAM_CLK;
    logic rst96;
    logic rst48;
    logic rst24;

    int          cycles = 0;    // clk_ext rising edges since start
    int          edge_cnt = 0;  // rising edges since rst_n was last seen low
    logic [15:0] hist [3];      // sampled reset cause per domain, bit 0 newest
    int          known [3];     // how many history bits are real samples
    int          checks = 0;
    int          errors = 0;
    logic [31:0] lfsr;

    board_clocks #(
        .LOCK_CYCLES ( LOCK_CYCLES           ),
        .ROM_SEL     ( clk_cfg_pkg::rom_48   ),
        .SYS_SEL     ( clk_cfg_pkg::sys_rom  ),
        .RST_STRETCH ( 8'(STRETCH)           )
    ) board_clocks_inst (
        .clk_ext    ( clk_ext    ),
        .rst_n      ( rst_n      ),
        .clk96      ( clk96      ),
        .clk48      ( clk48      ),
        .clk24      ( clk24      ),
        .pll_locked ( pll_locked ),
        .clk_sys    ( clk_sys    ),
        .clk_rom    ( clk_rom    ),
        .SDRAM_CLK  ( SDRAM_CLK  ),
        .game_rst   ( game_rst   ),
        .rst96      ( rst96      ),
        .rst48      ( rst48      ),
        .rst24      ( rst24      )
    );

    // 4 ns period
    initial begin
        clk_ext = 1'b0;
        forever #2 clk_ext = ~clk_ext;
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // one LFSR step per bit taken
    task automatic draw_bits(input int width, output int value);
        int i;
        value = 0;
        for (i = 0; i < width; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr_step(lfsr);
        end
    endtask

    // divided clocks as a function of edges since release
    function automatic logic ref_clk48(input int cnt);
        return (cnt % 2) == 1;
    endfunction

    function automatic logic ref_clk24(input int cnt);
        return ((cnt + 1) / 2) % 2 == 1;    // rises with every second clk48 rise
    endfunction

    // reset is high while any of the last STRETCH+1 samples before the newest
    // one saw a cause, result is {known, value}
    function automatic logic [1:0] window_rst(input logic [15:0] h, input int k);
        logic any_cause;
        int   i;
        any_cause = 1'b0;
        for (i = 1; i <= STRETCH + 1; i++) begin
            if (i < k && h[i]) begin
                any_cause = 1'b1;
            end
        end
        if (any_cause) begin
            return 2'b11;
        end else if (k >= STRETCH + 2) begin
            return 2'b10;
        end
        return 2'b00;                       // not enough history yet
    endfunction

    // {clk48, clk24, locked, k96, r96, k48, r48, k24, r24}
    function automatic logic [8:0] ref_outputs(input int cnt,
                                               input logic [15:0] h96, input int k96,
                                               input logic [15:0] h48, input int k48,
                                               input logic [15:0] h24, input int k24);
        return {ref_clk48(cnt), ref_clk24(cnt), cnt >= LOCK_CYCLES,
                window_rst(h96, k96), window_rst(h48, k48), window_rst(h24, k24)};
    endfunction

    // one domain edge, board reset fills the whole synchronizer at once
    task automatic record_cause(input int d, input logic c, input logic board_rst);
        hist[d]  = {hist[d][14:0], c};
        known[d] = known[d] + 1;
        if (board_rst) begin
            hist[d][1] = 1'b1;
            if (known[d] < 2) begin
                known[d] = 2;
            end
        end
    endtask

    // reference state, stepped on every clk_ext rise
    always @(posedge clk_ext) begin : model_step
        logic locked_pre;
        logic cause;
        logic old48;
        logic old24;
        locked_pre = (edge_cnt >= LOCK_CYCLES);
        old48      = ref_clk48(edge_cnt);
        old24      = ref_clk24(edge_cnt);
        cause      = !rst_n || !locked_pre || game_rst;
        if (!rst_n) begin
            edge_cnt = 0;
        end else begin
            edge_cnt = edge_cnt + 1;
        end
        record_cause(0, cause, !rst_n);
        // lock only moves on even counts, so slow domains see the same cause
        if (!old48 && ref_clk48(edge_cnt)) begin
            record_cause(1, cause, 1'b0);
        end
        if (!old24 && ref_clk24(edge_cnt)) begin
            record_cause(2, cause, 1'b0);
        end
        cycles = cycles + 1;
    end

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    // outputs are settled half a period after the rising edge
    always @(negedge clk_ext) begin : compare
        logic [8:0] exp;
        if (cycles > 0) begin
            exp = ref_outputs(edge_cnt, hist[0], known[0], hist[1], known[1],
                              hist[2], known[2]);
            check_bit("clk48", exp[8], clk48);
            check_bit("clk24", exp[7], clk24);
            check_bit("pll_locked", exp[6], pll_locked);
            if (exp[5]) begin
                check_bit("rst96", exp[4], rst96);
            end
            if (exp[3]) begin
                check_bit("rst48", exp[2], rst48);
            end
            if (exp[1]) begin
                check_bit("rst24", exp[0], rst24);
            end
            check_bit("clk_rom", exp[8], clk_rom);     // ROM runs from clk48
            check_bit("clk_sys", exp[8], clk_sys);     // system follows ROM
            check_bit("SDRAM_CLK", !exp[8], SDRAM_CLK);
        end
    end

    // clk96 follows clk_ext, looked at clear of both edges
    always @(clk_ext) begin : clk96_check
        #1;
        if (cycles > 0) begin
            check_bit("clk96", clk_ext, clk96);
        end
    end

    // lock must come exactly LOCK_CYCLES edges after release
    task automatic wait_lock(input int start);
        while (!pll_locked) begin
            @(negedge clk_ext);
        end
        checks++;
        if (cycles - start != LOCK_CYCLES) begin
            errors++;
            $display("FAILED at %0t ns: pll_locked rise expected after %0d cycles, got %0d",
                     $time, LOCK_CYCLES, cycles - start);
        end
    endtask

    task automatic wait_released();
        while (rst96 || rst48 || rst24) begin
            @(negedge clk_ext);
        end
    endtask

    task automatic board_reset();
        int start;
        rst_n = 1'b0;
        start = cycles;
        while (cycles < start + RESET_CYCLES) begin
            @(negedge clk_ext);
        end
        rst_n = 1'b1;
        wait_lock(cycles);
        wait_released();
    endtask

    task automatic pulse_game_rst(input int len, input int gap);
        game_rst = 1'b1;
        repeat (len) @(negedge clk_ext);
        game_rst = 1'b0;
        repeat (gap) @(negedge clk_ext);   // long enough for clk24 to release
    endtask

    initial begin : watchdog
        while (cycles < MAX_CYCLES) begin
            @(negedge clk_ext);
        end
        $display("timeout: run still going after %0d clk_ext cycles", MAX_CYCLES);
        $display("checks: %0d  errors: %0d", checks, errors);
        $display("Something failed");
        $finish;
    end

    initial begin : stimulus
        int i;
        int len;
        int gap;
        rst_n    = 1'b0;
        game_rst = 1'b0;
        lfsr     = 32'h8864ee03;
        for (i = 0; i < 3; i++) begin
            hist[i]  = '0;
            known[i] = 0;
        end
        while (cycles < RESET_CYCLES) begin
            @(negedge clk_ext);
        end
        rst_n = 1'b1;
        wait_lock(cycles);
        wait_released();
        repeat (20) @(negedge clk_ext);
        for (i = 0; i < PULSES; i++) begin
            draw_bits(3, len);
            draw_bits(6, gap);
            pulse_game_rst(len + 1, 40 + gap % 61);
        end
        board_reset();                      // second board reset, lock again
        repeat (20) @(negedge clk_ext);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
